//--- all.f
source/cpu_pkg.sv
source/debug_pkg.sv
source/registers_bank.sv
source/credit_counter.sv
source/dump_controller.sv
source/dump_output_stage.sv
source/regfile_debug_top.sv
sim/tb_regfile_debug.sv

//--- Bender.yml
package:
  name: regfile_debug

dependencies: {}

sources:
  # packages first, the RTL modules import them
  - source/cpu_pkg.sv
  - source/debug_pkg.sv

  # register bank and dump path
  - source/registers_bank.sv
  - source/credit_counter.sv
  - source/dump_controller.sv
  - source/dump_output_stage.sv

  # top level
  - source/regfile_debug_top.sv

  # testbench, top module tb_regfile_debug
  - target: test
    files:
      - sim/tb_regfile_debug.sv

//--- sim/tb_regfile_debug.sv
`default_nettype none

module tb_regfile_debug
    import cpu_pkg::*;
    import debug_pkg::*;
();

    // idle cycles allowed between two dump words
    localparam int WORD_TIMEOUT  = 64;
    // whole dump, credit pauses included
    localparam int DUMP_TIMEOUT  = 600;
    // receiver handing back its last credits
    localparam int DRAIN_TIMEOUT = 64;

    logic       clock;
    logic       reset;
    wb_req_t    wb_req;
    reg_addr_t  read_reg_a;
    reg_addr_t  read_reg_b;
    logic       dump_request;
    logic       credit_return;
    reg_data_t  data_a;
    reg_data_t  data_b;
    logic       dump_valid;
    dump_word_t dump;
    logic       stall;

    // reference copy of the bank
    reg_data_t model [BANK_DEPTH];

    integer seed;
    int     errors;
    int     checks;
    int     timeouts;
    // words sitting in the receiver buffer
    int     rx_count;
    int     fwd_hits;
    int     zero_writes;

    regfile_debug_top i_dut (
        .i_clock         (clock),
        .i_reset         (reset),
        .i_wb            (wb_req),
        .i_read_reg_a    (read_reg_a),
        .i_read_reg_b    (read_reg_b),
        .i_dump_request  (dump_request),
        .i_credit_return (credit_return),
        .o_data_a        (data_a),
        .o_data_b        (data_b),
        .o_dump_valid    (dump_valid),
        .o_dump          (dump),
        .o_stall         (stall)
    );

    always #4 clock = ~clock;

    task automatic expect_equal(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // one random write-back plus two reads, model updated only if the bank is live
    task automatic drive_random_access(input bit apply, output reg_data_t exp_a,
                                       output reg_data_t exp_b);
        logic [31:0] r;
        wb_req_t     req;
        reg_addr_t   ra;
        reg_addr_t   rb;
        r         = $random(seed);
        req.write = r[0] | r[1];
        req.addr  = r[6:2];
        // register 0 gets hit more often than chance
        if (r[10:8] == 3'd0) begin
            req.addr = '0;
        end
        req.data = $random(seed);
        ra       = r[15:11];
        rb       = r[20:16];
        // point reads at the write target now and then
        if (r[22:21] == 2'd0) begin
            ra = req.addr;
        end
        if (r[24:23] == 2'd0) begin
            rb = req.addr;
        end
        wb_req     <= req;
        read_reg_a <= ra;
        read_reg_b <= rb;
        // read sees the old contents unless forwarded
        exp_a = model[ra];
        exp_b = model[rb];
        if (apply && req.write && (req.addr == '0)) begin
            zero_writes++;
        end
        if (apply && req.write && (req.addr != '0)) begin
            if (ra == req.addr) begin
                exp_a = req.data;
                fwd_hits++;
            end
            if (rb == req.addr) begin
                exp_b = req.data;
                fwd_hits++;
            end
            model[req.addr] = req.data;
        end
    endtask

    // receiver frees a slot after a random delay, unless told to hold
    task automatic drive_credit(input bit hold);
        logic [31:0] r;
        r = $random(seed);
        if (!hold && (rx_count > 0) && (r[1:0] != 2'd0)) begin
            credit_return <= 1'b1;
            rx_count--;
        end else begin
            credit_return <= 1'b0;
        end
    endtask

    // results checked one cycle after the addresses go out
    task automatic run_traffic(input int cycles);
        reg_data_t exp_a;
        reg_data_t exp_b;
        reg_data_t prev_a;
        reg_data_t prev_b;
        bit        have_prev;
        have_prev = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(posedge clock);
            drive_random_access(1'b1, exp_a, exp_b);
            @(negedge clock);
            expect_equal("stall while idle", stall, 1'b0);
            expect_equal("dump valid while idle", dump_valid, 1'b0);
            if (have_prev) begin
                expect_equal("read port a", data_a, prev_a);
                expect_equal("read port b", data_b, prev_b);
            end
            prev_a    = exp_a;
            prev_b    = exp_b;
            have_prev = 1'b1;
        end
        // quiet cycle to collect the last result
        @(posedge clock);
        wb_req <= '0;
        @(negedge clock);
        expect_equal("read port a", data_a, prev_a);
        expect_equal("read port b", data_b, prev_b);
    endtask

    // full dump, credits withheld for the first hold_cycles cycles
    task automatic run_dump(input int hold_cycles);
        reg_data_t ignored_a;
        reg_data_t ignored_b;
        reg_data_t held_b;
        int        next_index;
        int        cycle;
        int        idle_cycles;
        int        waited;
        next_index  = 0;
        cycle       = 0;
        idle_cycles = 0;
        // port b reads this address until the stall, then freezes
        held_b      = model[read_reg_b];
        // request with write-back quiet
        @(posedge clock);
        wb_req       <= '0;
        dump_request <= 1'b1;
        drive_credit(1'b0);
        while ((next_index < BANK_DEPTH) && (timeouts == 0)) begin
            @(posedge clock);
            dump_request <= 1'b0;
            // pipeline held, none of this may land in the bank
            drive_random_access(1'b0, ignored_a, ignored_b);
            drive_credit(cycle < hold_cycles);
            @(negedge clock);
            cycle++;
            expect_equal("stall during dump", stall, 1'b1);
            expect_equal("read port b during dump", data_b, held_b);
            if (dump_valid) begin
                rx_count++;
                idle_cycles = 0;
                checks++;
                assert (rx_count <= DUMP_CREDITS) else begin
                    errors++;
                    $display("Fail at %0t: word %0d sent with no credit, receiver holds %0d",
                             $time, next_index, rx_count);
                end
                expect_equal("dump index", dump.index, next_index);
                expect_equal("dump data", dump.data, model[next_index]);
                expect_equal("dump last", dump.last, next_index == BANK_DEPTH - 1);
                next_index++;
            end else begin
                idle_cycles++;
            end
            // dump must have paused once the buffer filled
            if ((hold_cycles > 0) && (cycle == hold_cycles)) begin
                expect_equal("words sent while credits held", next_index, DUMP_CREDITS);
            end
            if ((idle_cycles > WORD_TIMEOUT) || (cycle > DUMP_TIMEOUT)) begin
                timeouts++;
                $display("timed out waiting for dump word %0d", next_index);
            end
        end
        if (timeouts == 0) begin
            // stall drops the cycle after the last word
            @(posedge clock);
            wb_req <= '0;
            drive_credit(1'b0);
            @(negedge clock);
            expect_equal("stall after dump", stall, 1'b0);
            expect_equal("dump valid after dump", dump_valid, 1'b0);
            // hand the remaining credits back
            waited = 0;
            while ((rx_count > 0) && (waited < DRAIN_TIMEOUT)) begin
                @(posedge clock);
                drive_credit(1'b0);
                @(negedge clock);
                waited++;
            end
            if (rx_count > 0) begin
                timeouts++;
                $display("timed out returning credits, %0d still held", rx_count);
            end
            @(posedge clock);
            credit_return <= 1'b0;
        end
    endtask

    initial begin
        seed          = 32'hdd3858a4;
        clock         = 1'b0;
        reset         = 1'b1;
        wb_req        = '0;
        read_reg_a    = '0;
        read_reg_b    = '0;
        dump_request  = 1'b0;
        credit_return = 1'b0;
        errors        = 0;
        checks        = 0;
        timeouts      = 0;
        rx_count      = 0;
        fwd_hits      = 0;
        zero_writes   = 0;
        for (int i = 0; i < BANK_DEPTH; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        // state right out of reset
        expect_equal("stall after reset", stall, 1'b0);
        expect_equal("dump valid after reset", dump_valid, 1'b0);
        expect_equal("port a after reset", data_a, '0);
        expect_equal("port b after reset", data_b, '0);
        run_traffic(300);
        if (timeouts == 0) begin
            run_dump(0);
        end
        if (timeouts == 0) begin
            run_traffic(200);
        end
        if (timeouts == 0) begin
            run_dump(20);
        end
        if (timeouts == 0) begin
            run_traffic(200);
        end
        // random traffic has to have reached both corner cases
        checks++;
        assert (fwd_hits > 0) else begin
            errors++;
            $display("no read was ever forwarded from a same-cycle write");
        end
        checks++;
        assert (zero_writes > 0) else begin
            errors++;
            $display("no write to register 0 was ever issued");
        end
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if ((errors == 0) && (timeouts == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- source/regfile_debug_top.sv
`default_nettype none

module regfile_debug_top
    import cpu_pkg::*;
    import debug_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_reset,
    input  wire wb_req_t   i_wb,
    input  wire reg_addr_t i_read_reg_a,
    input  wire reg_addr_t i_read_reg_b,
    input  wire logic      i_dump_request,
    input  wire logic      i_credit_return,
    output reg_data_t      o_data_a,
    output reg_data_t      o_data_b,
    output logic           o_dump_valid,
    output dump_word_t     o_dump,
    output logic           o_stall
);

    logic      stall;
    logic      issue;
    reg_addr_t dump_index;
    logic      dump_last;
    logic      credit_available;

    // bank runs normally unless a dump holds the pipeline
    registers_bank u_bank (
        .i_clock         (i_clock),
        .i_reset         (i_reset),
        .i_enable        (!stall),
        .i_wb            (i_wb),
        .i_read_reg_a    (i_read_reg_a),
        .i_read_reg_b    (i_read_reg_b),
        .i_debug_read    (issue),
        .i_debug_address (dump_index),
        .o_data_a        (o_data_a),
        .o_data_b        (o_data_b)
    );

    dump_controller u_ctrl (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .i_dump_request     (i_dump_request),
        .i_credit_available (credit_available),
        .o_stall            (stall),
        .o_issue            (issue),
        .o_index            (dump_index),
        .o_last             (dump_last)
    );

    // credit taken at issue, not at presentation
    credit_counter u_credits (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_take      (issue),
        .i_return    (i_credit_return),
        .o_available (credit_available)
    );

    dump_output_stage u_out (
        .i_clock      (i_clock),
        .i_reset      (i_reset),
        .i_issue      (issue),
        .i_index      (dump_index),
        .i_last       (dump_last),
        .i_data       (o_data_a),
        .o_dump_valid (o_dump_valid),
        .o_dump       (o_dump)
    );

    assign o_stall = stall;

endmodule

`default_nettype wire

//--- source/dump_output_stage.sv
`default_nettype none

module dump_output_stage
    import cpu_pkg::*;
    import debug_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_reset,
    input  wire logic      i_issue,
    input  wire reg_addr_t i_index,
    input  wire logic      i_last,
    // bank port a, one cycle behind the issue
    input  wire reg_data_t i_data,
    output logic           o_dump_valid,
    output dump_word_t     o_dump
);

    logic      valid_q;
    reg_addr_t index_q;
    logic      last_q;

    // control side of the word
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_issue;
        end
    end

    // tag travels alongside the read
    always_ff @(posedge i_clock) begin
        index_q <= i_index;
        last_q  <= i_last;
    end

    assign o_dump_valid = valid_q;

    // data comes straight from the bank register
    assign o_dump.index = index_q;
    assign o_dump.data  = i_data;
    assign o_dump.last  = last_q;

endmodule

`default_nettype wire

//--- source/dump_controller.sv
`default_nettype none

module dump_controller
    import cpu_pkg::*;
    import debug_pkg::*;
(
    input  wire logic i_clock,
    input  wire logic i_reset,
    // one-cycle pulse, ignored unless idle
    input  wire logic i_dump_request,
    input  wire logic i_credit_available,
    output logic      o_stall,
    // one bank read this cycle
    output logic      o_issue,
    output reg_addr_t o_index,
    // index is the final register
    output logic      o_last
);

    localparam reg_addr_t LAST_INDEX = reg_addr_t'(BANK_DEPTH - 1);

    dump_state_t state_q;
    dump_state_t state_d;
    reg_addr_t   index_q;
    reg_addr_t   index_d;

    logic at_last;

    assign at_last = (index_q == LAST_INDEX);

    // reads go out only against a credit
    assign o_issue = (state_q == ST_DUMP) && i_credit_available;

    always_comb begin
        state_d = state_q;
        index_d = index_q;
        case (state_q)
            ST_IDLE: begin
                if (i_dump_request) begin
                    // every dump starts at register 0
                    state_d = ST_DUMP;
                    index_d = '0;
                end
            end
            ST_DUMP: begin
                // no credit means index holds
                if (o_issue) begin
                    if (at_last) begin
                        state_d = ST_DRAIN;
                    end else begin
                        index_d = index_q + 1'b1;
                    end
                end
            end
            ST_DRAIN: begin
                // final word is on the link this cycle
                state_d = ST_IDLE;
            end
            default: begin
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state_q <= ST_IDLE;
            index_q <= '0;
        end else begin
            state_q <= state_d;
            index_q <= index_d;
        end
    end

    // pipeline held for the whole walk plus drain
    assign o_stall = (state_q != ST_IDLE);
    assign o_index = index_q;
    assign o_last  = at_last;

    // an issued read lands while the pipeline is still held
    a_issue_in_dump : assert property (
        @(posedge i_clock) disable iff (i_reset)
        o_issue |-> (state_q == ST_DUMP) ##1 o_stall
    );

endmodule

`default_nettype wire

//--- source/credit_counter.sv
`default_nettype none

module credit_counter
    import debug_pkg::*;
(
    input  wire logic i_clock,
    input  wire logic i_reset,
    // read issued, one word now owed to the receiver
    input  wire logic i_take,
    // receiver freed a buffer slot
    input  wire logic i_return,
    output logic      o_available
);

    logic [CREDIT_BITS-1:0] count_q;
    logic [CREDIT_BITS-1:0] count_d;

    // take and return may land together
    always_comb begin
        case ({i_return, i_take})
            2'b10:   count_d = count_q + 1'b1;
            2'b01:   count_d = count_q - 1'b1;
            default: count_d = count_q;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            // receiver buffer starts empty
            count_q <= CREDIT_BITS'(DUMP_CREDITS);
        end else begin
            count_q <= count_d;
        end
    end

    // words in flight already hold their credit
    assign o_available = (count_q != '0);

    // controller must only issue against a credit
    a_no_take_empty : assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_take |-> (count_q != '0)
    );

    // receiver never returns more than it was sent
    a_no_overflow : assert property (
        @(posedge i_clock) disable iff (i_reset)
        (i_return && !i_take) |-> (count_q < CREDIT_BITS'(DUMP_CREDITS))
    );

endmodule

`default_nettype wire

//--- source/registers_bank.sv
`default_nettype none

module registers_bank
    import cpu_pkg::*;
(
    input  wire logic      i_clock,
    input  wire logic      i_reset,
    // low while the pipeline is stalled
    input  wire logic      i_enable,
    input  wire wb_req_t   i_wb,
    input  wire reg_addr_t i_read_reg_a,
    input  wire reg_addr_t i_read_reg_b,
    // debug read, only looked at while disabled
    input  wire logic      i_debug_read,
    input  wire reg_addr_t i_debug_address,
    output reg_data_t      o_data_a,
    output reg_data_t      o_data_b
);

    reg_data_t registers [BANK_DEPTH];

    // register 0 is hardwired, a write to it goes nowhere
    logic wb_valid;
    // same-cycle write hits a read address
    logic fwd_a;
    logic fwd_b;

    assign wb_valid = i_wb.write && (i_wb.addr != '0);
    assign fwd_a    = wb_valid && (i_wb.addr == i_read_reg_a);
    assign fwd_b    = wb_valid && (i_wb.addr == i_read_reg_b);

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            // whole bank cleared
            for (int i = 0; i < BANK_DEPTH; i++) begin
                registers[i] <= '0;
            end
            o_data_a <= '0;
            o_data_b <= '0;
        end else if (i_enable) begin
            if (wb_valid) begin
                registers[i_wb.addr] <= i_wb.data;
            end
            // new data goes straight to the read port
            // so the pipeline sees it a cycle early
            if (fwd_a) begin
                o_data_a <= i_wb.data;
            end else begin
                o_data_a <= registers[i_read_reg_a];
            end
            if (fwd_b) begin
                o_data_b <= i_wb.data;
            end else begin
                o_data_b <= registers[i_read_reg_b];
            end
        end else if (i_debug_read) begin
            // dump path shares port a
            // port b keeps its last value while stalled
            o_data_a <= registers[i_debug_address];
        end
    end

    // dump reads only come in while the pipeline is held
    a_debug_only_stalled : assert property (
        @(posedge i_clock) disable iff (i_reset)
        i_enable |-> !i_debug_read
    );

    // zero register reads back as zero on either port
    a_reg0_zero_a : assert property (
        @(posedge i_clock) disable iff (i_reset)
        (i_enable && (i_read_reg_a == '0)) |=> (o_data_a == '0)
    );

    a_reg0_zero_b : assert property (
        @(posedge i_clock) disable iff (i_reset)
        (i_enable && (i_read_reg_b == '0)) |=> (o_data_b == '0)
    );

endmodule

`default_nettype wire

//--- source/debug_pkg.sv
`default_nettype none

package debug_pkg;

    // dump words carry register indexes and data
    import cpu_pkg::*;

    // receiver buffer depth, also the credits held out of reset
    localparam int DUMP_CREDITS = 4;

    // count runs 0..DUMP_CREDITS inclusive
    localparam int CREDIT_BITS = 3;

    // one word on the debug link
    // last marks the final register of a dump
    typedef struct packed {
        reg_addr_t index;
        reg_data_t data;
        logic      last;
    } dump_word_t;

    // idle waits for a request, dump walks the bank,
    // drain covers the cycle the final word is on the link
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_DUMP  = 2'd1,
        ST_DRAIN = 2'd2
    } dump_state_t;

endpackage

`default_nettype wire

//--- source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // width of one architectural register
    localparam int NB_DATA = 32;

    // enough bits to name every register
    localparam int NB_ADDR = 5;

    // full bank, register 0 included
    localparam int BANK_DEPTH = 32;

    typedef logic [NB_DATA-1:0] reg_data_t;

    typedef logic [NB_ADDR-1:0] reg_addr_t;

    // request coming back from write-back
    // write flag, then target register, then payload
    typedef struct packed {
        logic      write;
        reg_addr_t addr;
        reg_data_t data;
    } wb_req_t;

endpackage

`default_nettype wire
